//--- Bender.yml
package:
  name: gcn_classifier

sources:
  - hw/gcn_dims_pkg.sv
  - hw/gcn_ctrl_pkg.sv
  - hw/gcn_controller.sv
  - hw/adjacency_builder.sv
  - hw/feature_aggregator.sv
  - hw/class_score_mac.sv
  - hw/argmax_classifier.sv
  - hw/gcn_top.sv
  - target: test
    files:
      - tb/gcn_tb.sv

//--- build.f
hw/gcn_dims_pkg.sv
hw/gcn_ctrl_pkg.sv
hw/gcn_controller.sv
hw/adjacency_builder.sv
hw/feature_aggregator.sv
hw/class_score_mac.sv
hw/argmax_classifier.sv
hw/gcn_top.sv
tb/gcn_tb.sv

//--- hw/adjacency_builder.sv
module adjacency_builder (
    input  logic                                                         clk,
    input  logic                                                         rst_n,
    input  logic                                                         start,
    input  gcn_dims_pkg::node_id_t [gcn_dims_pkg::NUM_EDGES-1:0]          edge_src,
    input  gcn_dims_pkg::node_id_t [gcn_dims_pkg::NUM_EDGES-1:0]          edge_dst,
    input  logic                                                         adj_en,
    output logic                                                         adj_done,
    output logic [gcn_dims_pkg::NUM_NODES-1:0][gcn_dims_pkg::NUM_NODES-1:0] adj
);
    import gcn_dims_pkg::*;

    node_id_t [NUM_EDGES-1:0] src_r;
    node_id_t [NUM_EDGES-1:0] dst_r;
    logic [2:0]               slot;
    node_id_t                 cur_src;
    node_id_t                 cur_dst;
    logic [2:0]               src_idx;
    logic [2:0]               dst_idx;
    logic                     edge_valid;

    function automatic logic id_valid(node_id_t id);
        return (id != '0) && (int'(id) <= NUM_NODES);
    endfunction

    function automatic logic is_symmetric(logic [NUM_NODES-1:0][NUM_NODES-1:0] m);
        logic ok;
        ok = 1'b1;
        for (int r = 0; r < NUM_NODES; r++) begin
            for (int c = 0; c < NUM_NODES; c++) begin
                if (m[r][c] != m[c][r]) begin
                    ok = 1'b0;
                end
            end
        end
        return ok;
    endfunction

    // edge list held for the whole build
    always_ff @(posedge clk) begin
        if (start) begin
            src_r <= edge_src;
            dst_r <= edge_dst;
        end
    end

    assign cur_src    = src_r[slot];
    assign cur_dst    = dst_r[slot];
    // ids are one based
    assign src_idx    = cur_src - 3'd1;
    assign dst_idx    = cur_dst - 3'd1;
    assign edge_valid = id_valid(cur_src) && id_valid(cur_dst);
    assign adj_done   = adj_en && (slot == 3'(NUM_EDGES - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            adj  <= '0;
            slot <= '0;
        end else if (start) begin
            adj  <= '0;
            slot <= '0;
        end else if (adj_en) begin
            // self-loop sets the same bit twice
            if (edge_valid) begin
                adj[src_idx][dst_idx] <= 1'b1;
                adj[dst_idx][src_idx] <= 1'b1;
            end
            slot <= adj_done ? '0 : slot + 3'd1;
        end
    end

    a_adj_sym: assert property (@(posedge clk) disable iff (!rst_n)
        adj_done |-> is_symmetric(adj));

endmodule

//--- hw/argmax_classifier.sv
module argmax_classifier (
    input  logic clk,
    input  logic rst_n,
    input  logic classify_en,
    input  gcn_dims_pkg::score_t [gcn_dims_pkg::NUM_NODES-1:0][gcn_dims_pkg::NUM_CLASSES-1:0]
                 scores,
    output logic class_done,
    output gcn_dims_pkg::class_t [gcn_dims_pkg::NUM_NODES-1:0] y
);
    import gcn_dims_pkg::*;

    class_t                 cls;
    score_t [NUM_NODES-1:0] best;
    class_t [NUM_NODES-1:0] best_idx;
    score_t [NUM_NODES-1:0] best_next;
    class_t [NUM_NODES-1:0] idx_next;

    assign class_done = classify_en && (cls == class_t'(NUM_CLASSES - 1));

    //////////////////////////////////////////////////
    // one class per cycle
    //////////////////////////////////////////////////
    // class 0 seeds the scan
    // later classes need a strictly greater score so ties keep the lower index
    always_comb begin
        for (int n = 0; n < NUM_NODES; n++) begin
            if ((cls == '0) || (scores[n][cls] > best[n])) begin
                best_next[n] = scores[n][cls];
                idx_next[n]  = cls;
            end else begin
                best_next[n] = best[n];
                idx_next[n]  = best_idx[n];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cls      <= '0;
            best     <= '0;
            best_idx <= '0;
            y        <= '0;
        end else if (classify_en) begin
            cls      <= class_done ? '0 : cls + 1'b1;
            best     <= best_next;
            best_idx <= idx_next;
            // new result shows in the cycle done pulses
            if (class_done) begin
                y <= idx_next;
            end
        end
    end

endmodule

//--- hw/class_score_mac.sv
module class_score_mac (
    input  logic clk,
    input  logic rst_n,
    input  logic mac_clear,
    input  gcn_dims_pkg::agg_t [gcn_dims_pkg::NUM_NODES-1:0][gcn_dims_pkg::LANES-1:0]
                 agg,
    input  gcn_dims_pkg::feat_t [gcn_dims_pkg::LANES-1:0][gcn_dims_pkg::NUM_CLASSES-1:0]
                 weight_rows,
    output gcn_dims_pkg::score_t [gcn_dims_pkg::NUM_NODES-1:0][gcn_dims_pkg::NUM_CLASSES-1:0]
                 scores
);
    import gcn_dims_pkg::*;

    feat_t  [LANES-1:0][NUM_CLASSES-1:0]     weight_r;
    score_t [NUM_NODES-1:0][NUM_CLASSES-1:0] pair_sum;

    // weights wait one cycle to meet their registered sums
    always_ff @(posedge clk) begin
        weight_r <= weight_rows;
    end

    //////////////////////////////////////////////////
    // products of both lanes
    //////////////////////////////////////////////////
    always_comb begin
        for (int n = 0; n < NUM_NODES; n++) begin
            for (int c = 0; c < NUM_CLASSES; c++) begin
                pair_sum[n][c] = '0;
                for (int l = 0; l < LANES; l++) begin
                    pair_sum[n][c] = pair_sum[n][c]
                                   + score_t'(agg[n][l]) * score_t'(weight_r[l][c]);
                end
            end
        end
    end

    // running class scores
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scores <= '0;
        end else if (mac_clear) begin
            scores <= '0;
        end else begin
            for (int n = 0; n < NUM_NODES; n++) begin
                for (int c = 0; c < NUM_CLASSES; c++) begin
                    scores[n][c] <= scores[n][c] + pair_sum[n][c];
                end
            end
        end
    end

endmodule

//--- hw/feature_aggregator.sv
module feature_aggregator (
    input  logic                                                          clk,
    input  logic                                                          rst_n,
    input  logic                                                          stream_en,
    input  logic [gcn_dims_pkg::NUM_NODES-1:0][gcn_dims_pkg::NUM_NODES-1:0]  adj,
    input  gcn_dims_pkg::feat_t [gcn_dims_pkg::LANES-1:0][gcn_dims_pkg::NUM_NODES-1:0]
                                                                          feat_cols,
    output gcn_dims_pkg::agg_t [gcn_dims_pkg::NUM_NODES-1:0][gcn_dims_pkg::LANES-1:0]
                                                                          agg
);
    import gcn_dims_pkg::*;

    agg_t [NUM_NODES-1:0][LANES-1:0] agg_next;

    //////////////////////////////////////////////////
    // neighbour sums
    //////////////////////////////////////////////////
    // row n of adj picks the neighbours of node n
    always_comb begin
        agg_next = '0;
        for (int n = 0; n < NUM_NODES; n++) begin
            for (int l = 0; l < LANES; l++) begin
                for (int m = 0; m < NUM_NODES; m++) begin
                    if (adj[n][m]) begin
                        agg_next[n][l] = agg_next[n][l] + agg_t'(feat_cols[l][m]);
                    end
                end
            end
        end
    end

    // zero outside stream so drain cycles add nothing
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            agg <= '0;
        end else if (stream_en) begin
            agg <= agg_next;
        end else begin
            agg <= '0;
        end
    end

endmodule

//--- hw/gcn_controller.sv
module gcn_controller (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  logic                     adj_done,
    input  logic                     class_done,
    output logic                     adj_en,
    output logic                     stream_en,
    output logic                     mac_clear,
    output logic                     classify_en,
    output logic                     feat_re,
    output gcn_dims_pkg::pair_addr_t feat_addr,
    output logic                     busy,
    output logic                     done
);
    import gcn_dims_pkg::*;
    import gcn_ctrl_pkg::*;

    gcn_state_t state;
    gcn_state_t state_next;
    logic [1:0] drain_cnt;
    logic       last_pair;
    logic       last_drain;

    assign last_pair  = (feat_addr == pair_addr_t'(NUM_PAIRS - 1));
    assign last_drain = (drain_cnt == 2'(DRAIN_CYCLES - 1));

    //////////////////////////////////////////////////
    // phase sequencing
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                // start only matters here
                if (start) begin
                    state_next = build_adj;
                end
            end
            build_adj: begin
                if (adj_done) begin
                    state_next = stream;
                end
            end
            stream: begin
                if (last_pair) begin
                    state_next = drain;
                end
            end
            drain: begin
                if (last_drain) begin
                    state_next = classify;
                end
            end
            classify: begin
                if (class_done) begin
                    state_next = finish;
                end
            end
            finish: begin
                state_next = idle;
            end
            default: begin
                state_next = idle;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // counters
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            feat_addr <= '0;
            drain_cnt <= '0;
        end else begin
            // column pair address, back to 0 after the last pair
            if (state == stream) begin
                feat_addr <= last_pair ? '0 : feat_addr + 1'b1;
            end
            if (state == drain) begin
                drain_cnt <= last_drain ? '0 : drain_cnt + 1'b1;
            end
        end
    end

    // phase strobes
    assign adj_en      = (state == build_adj);
    assign stream_en   = (state == stream);
    assign feat_re     = (state == stream);
    assign classify_en = (state == classify);
    assign mac_clear   = (state == idle) && start;
    assign busy        = (state != idle);
    assign done        = (state == finish);

    // memory address stays in range while reading
    a_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
        feat_re |-> feat_addr <= pair_addr_t'(NUM_PAIRS - 1));

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done);

endmodule

//--- hw/gcn_ctrl_pkg.sv
package gcn_ctrl_pkg;

    //////////////////////////////////////////////////
    // run phases
    //////////////////////////////////////////////////
    // in the order a run walks through them
    typedef enum logic [2:0] {
        idle,
        build_adj,
        stream,
        drain,
        classify,
        finish
    } gcn_state_t;

    // aggregate register plus accumulate register
    localparam int DRAIN_CYCLES = 2;

endpackage

//--- hw/gcn_dims_pkg.sv
package gcn_dims_pkg;

    //////////////////////////////////////////////////
    // graph and feature sizes
    //////////////////////////////////////////////////
    localparam int NUM_NODES   = 6;
    localparam int NUM_EDGES   = 6;
    localparam int NUM_FEATS   = 96;
    // two feature columns per cycle
    localparam int LANES       = 2;
    localparam int NUM_PAIRS   = NUM_FEATS / LANES;
    localparam int NUM_CLASSES = 3;
    localparam int FEAT_W      = 5;

    //////////////////////////////////////////////////
    // data types
    //////////////////////////////////////////////////
    // ids 1 to 6 name a node, 0 and 7 mark an unused slot
    typedef logic [2:0]        node_id_t;
    typedef logic [FEAT_W-1:0] feat_t;
    // six five-bit values fit in eight bits
    typedef logic [7:0]        agg_t;
    typedef logic [19:0]       score_t;
    typedef logic [5:0]        pair_addr_t;
    typedef logic [1:0]        class_t;

endpackage

//--- hw/gcn_top.sv
module gcn_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  gcn_dims_pkg::node_id_t [gcn_dims_pkg::NUM_EDGES-1:0] edge_src,
    input  gcn_dims_pkg::node_id_t [gcn_dims_pkg::NUM_EDGES-1:0] edge_dst,
    input  gcn_dims_pkg::feat_t [gcn_dims_pkg::LANES-1:0][gcn_dims_pkg::NUM_NODES-1:0]
                                     feat_cols,
    input  gcn_dims_pkg::feat_t [gcn_dims_pkg::LANES-1:0][gcn_dims_pkg::NUM_CLASSES-1:0]
                                     weight_rows,
    output logic                     feat_re,
    output gcn_dims_pkg::pair_addr_t feat_addr,
    output gcn_dims_pkg::class_t [gcn_dims_pkg::NUM_NODES-1:0] y,
    output logic                     busy,
    output logic                     done
);
    import gcn_dims_pkg::*;

    logic adj_en;
    logic adj_done;
    logic stream_en;
    logic mac_clear;
    logic classify_en;
    logic class_done;

    logic [NUM_NODES-1:0][NUM_NODES-1:0]     adj;
    agg_t [NUM_NODES-1:0][LANES-1:0]         agg;
    score_t [NUM_NODES-1:0][NUM_CLASSES-1:0] scores;

    //////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////
    gcn_controller u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .adj_done    (adj_done),
        .class_done  (class_done),
        .adj_en      (adj_en),
        .stream_en   (stream_en),
        .mac_clear   (mac_clear),
        .classify_en (classify_en),
        .feat_re     (feat_re),
        .feat_addr   (feat_addr),
        .busy        (busy),
        .done        (done)
    );

    //////////////////////////////////////////////////
    // datapath
    //////////////////////////////////////////////////
    // edges are taken only while idle
    adjacency_builder u_adj (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start && !busy),
        .edge_src (edge_src),
        .edge_dst (edge_dst),
        .adj_en   (adj_en),
        .adj_done (adj_done),
        .adj      (adj)
    );

    feature_aggregator u_agg (
        .clk       (clk),
        .rst_n     (rst_n),
        .stream_en (stream_en),
        .adj       (adj),
        .feat_cols (feat_cols),
        .agg       (agg)
    );

    class_score_mac u_mac (
        .clk         (clk),
        .rst_n       (rst_n),
        .mac_clear   (mac_clear),
        .agg         (agg),
        .weight_rows (weight_rows),
        .scores      (scores)
    );

    argmax_classifier u_argmax (
        .clk         (clk),
        .rst_n       (rst_n),
        .classify_en (classify_en),
        .scores      (scores),
        .class_done  (class_done),
        .y           (y)
    );

endmodule

//--- tb/gcn_tb.sv
module gcn_tb;
    import gcn_dims_pkg::*;

    typedef class_t [NUM_NODES-1:0] y_vec_t;

    localparam int MAX_CYCLES = 20 * 80;

    logic clk;
    logic rst_n;
    logic start;
    node_id_t [NUM_EDGES-1:0]            edge_src;
    node_id_t [NUM_EDGES-1:0]            edge_dst;
    feat_t [LANES-1:0][NUM_NODES-1:0]    feat_cols;
    feat_t [LANES-1:0][NUM_CLASSES-1:0]  weight_rows;
    logic       feat_re;
    pair_addr_t feat_addr;
    y_vec_t     y;
    logic       busy;
    logic       done;

    // external memories with one row per feature column
    feat_t feat_mem [NUM_FEATS][NUM_NODES];
    feat_t weight_mem [NUM_FEATS][NUM_CLASSES];

    node_id_t [NUM_EDGES-1:0] src_list;
    node_id_t [NUM_EDGES-1:0] dst_list;
    y_vec_t      exp_y;
    y_vec_t      y_prev;
    logic [31:0] rng_state;
    int          err_value;
    int          err_other;
    int          cycles;
    int          addr_expect;
    int          re_count;

    gcn_top uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .edge_src    (edge_src),
        .edge_dst    (edge_dst),
        .feat_cols   (feat_cols),
        .weight_rows (weight_rows),
        .feat_re     (feat_re),
        .feat_addr   (feat_addr),
        .y           (y),
        .busy        (busy),
        .done        (done)
    );

    // columns 2a and 2a+1 in the same cycle
    for (genvar l = 0; l < LANES; l++) begin : g_lane
        for (genvar m = 0; m < NUM_NODES; m++) begin : g_feat
            assign feat_cols[l][m] = feat_mem[2 * feat_addr + l][m];
        end
        for (genvar c = 0; c < NUM_CLASSES; c++) begin : g_weight
            assign weight_rows[l][c] = weight_mem[2 * feat_addr + l][c];
        end
    end

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // neighbour sums times weights then lowest index of the maximum
    function automatic y_vec_t ref_classes();
        logic   adj_m [NUM_NODES][NUM_NODES];
        longint score [NUM_CLASSES];
        longint nsum;
        int     s;
        int     d;
        int     best;
        y_vec_t res;
        for (int r = 0; r < NUM_NODES; r++) begin
            for (int c = 0; c < NUM_NODES; c++) begin
                adj_m[r][c] = 1'b0;
            end
        end
        for (int e = 0; e < NUM_EDGES; e++) begin
            s = int'(src_list[e]);
            d = int'(dst_list[e]);
            if (s >= 1 && s <= NUM_NODES && d >= 1 && d <= NUM_NODES) begin
                adj_m[s-1][d-1] = 1'b1;
                adj_m[d-1][s-1] = 1'b1;
            end
        end
        for (int n = 0; n < NUM_NODES; n++) begin
            for (int c = 0; c < NUM_CLASSES; c++) begin
                score[c] = 0;
            end
            for (int k = 0; k < NUM_FEATS; k++) begin
                nsum = 0;
                for (int m = 0; m < NUM_NODES; m++) begin
                    if (adj_m[n][m]) begin
                        nsum += int'(feat_mem[k][m]);
                    end
                end
                for (int c = 0; c < NUM_CLASSES; c++) begin
                    score[c] += nsum * int'(weight_mem[k][c]);
                end
            end
            best = 0;
            for (int c = 1; c < NUM_CLASSES; c++) begin
                if (score[c] > score[best]) begin
                    best = c;
                end
            end
            res[n] = class_t'(best);
        end
        return res;
    endfunction

    task automatic check_class(input class_t got, input class_t exp, input int node);
        if (got !== exp) begin
            $display("[FAIL] %0t: node %0d class %0d, expected %0d", $time, node, got, exp);
            err_value++;
        end
    endtask

    task automatic check_addr(input pair_addr_t got, input pair_addr_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t: feat_addr %0d, expected %0d", $time, got, exp);
            err_value++;
        end
    endtask

    task automatic set_edge(input int slot, input int s, input int d);
        src_list[slot] = node_id_t'(s);
        dst_list[slot] = node_id_t'(d);
    endtask

    task automatic fill_random();
        for (int k = 0; k < NUM_FEATS; k++) begin
            for (int m = 0; m < NUM_NODES; m++) begin
                feat_mem[k][m] = feat_t'(next_rand());
            end
            for (int c = 0; c < NUM_CLASSES; c++) begin
                weight_mem[k][c] = feat_t'(next_rand());
            end
        end
    endtask

    // one run with an optional start pulse while busy
    task automatic run_graph(input int mid_start_at);
        @(posedge clk);
        edge_src <= src_list;
        edge_dst <= dst_list;
        start    <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        if (mid_start_at > 0) begin
            repeat (mid_start_at) @(posedge clk);
            start    <= 1'b1;
            edge_src <= {NUM_EDGES{3'd1}};
            edge_dst <= {NUM_EDGES{3'd1}};
            @(posedge clk);
            start <= 1'b0;
        end
        @(negedge clk);
        while (!done) begin
            if (busy !== 1'b1) begin
                $display("[FAIL] %0t: busy low while a run is in progress", $time);
                err_value++;
            end
            @(negedge clk);
        end
        if (busy !== 1'b1) begin
            $display("[FAIL] %0t: busy low in the done cycle", $time);
            err_value++;
        end
        // back in idle one cycle after done
        @(negedge clk);
        if (busy !== 1'b0) begin
            $display("[FAIL] %0t: busy still high after done", $time);
            err_value++;
        end
    endtask

    //////////////////////////////////////////////////
    // monitors
    //////////////////////////////////////////////////
    // result compare and hold check
    always @(negedge clk) begin
        if (rst_n) begin
            if (done) begin
                for (int n = 0; n < NUM_NODES; n++) begin
                    check_class(y[n], exp_y[n], n);
                end
            end else if (y !== y_prev) begin
                $display("y changed at %0t while done was low", $time);
                err_other++;
            end
            y_prev = y;
        end
    end

    // memory reads in order and 48 per run
    always @(negedge clk) begin
        if (rst_n) begin
            if (feat_re) begin
                check_addr(feat_addr, pair_addr_t'(addr_expect));
                addr_expect++;
                re_count++;
            end
            if (done) begin
                if (re_count != NUM_PAIRS) begin
                    $display("run at %0t had %0d read cycles instead of %0d",
                             $time, re_count, NUM_PAIRS);
                    err_other++;
                end
                re_count    = 0;
                addr_expect = 0;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the run never finished", cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////
    initial begin
        rst_n       = 1'b0;
        start       = 1'b0;
        edge_src    = '0;
        edge_dst    = '0;
        src_list    = '0;
        dst_list    = '0;
        exp_y       = '0;
        y_prev      = '0;
        rng_state   = 32'he887_c766;
        err_value   = 0;
        err_other   = 0;
        cycles      = 0;
        addr_expect = 0;
        re_count    = 0;
        fill_random();
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        @(negedge clk);
        if (busy !== 1'b0 || done !== 1'b0 || feat_re !== 1'b0) begin
            $display("[FAIL] %0t: busy, done or feat_re not low after reset", $time);
            err_value++;
        end
        check_addr(feat_addr, pair_addr_t'(0));
        for (int n = 0; n < NUM_NODES; n++) begin
            check_class(y[n], class_t'(0), n);
        end

        // chain 1-2-3-4-5-6 with the last slot unused
        @(negedge clk);
        for (int e = 0; e < NUM_EDGES - 1; e++) begin
            set_edge(e, e + 1, e + 2);
        end
        set_edge(NUM_EDGES - 1, 0, 0);
        fill_random();
        exp_y = ref_classes();
        run_graph(0);

        // no valid edge so every score is zero and class 0 wins the tie
        @(negedge clk);
        set_edge(0, 0, 3);
        set_edge(1, 7, 2);
        set_edge(2, 0, 0);
        set_edge(3, 7, 7);
        set_edge(4, 5, 0);
        set_edge(5, 1, 7);
        fill_random();
        exp_y = '0;
        run_graph(0);

        // self-loops plus a reversed and a repeated edge
        @(negedge clk);
        set_edge(0, 1, 1);
        set_edge(1, 2, 3);
        set_edge(2, 3, 2);
        set_edge(3, 2, 3);
        set_edge(4, 4, 4);
        set_edge(5, 5, 6);
        fill_random();
        exp_y = ref_classes();
        run_graph(0);

        // same graph and data without the duplicates
        @(negedge clk);
        set_edge(2, 0, 0);
        set_edge(3, 7, 0);
        exp_y = ref_classes();
        run_graph(0);

        for (int r = 0; r < 15; r++) begin
            @(negedge clk);
            for (int e = 0; e < NUM_EDGES; e++) begin
                set_edge(e, int'(next_rand() % 8), int'(next_rand() % 8));
            end
            fill_random();
            exp_y = ref_classes();
            run_graph(3 + int'(next_rand() % 40));
        end

        repeat (3) @(posedge clk);
        $display("errors: %0d value mismatches, %0d other failures", err_value, err_other);
        if (err_value == 0 && err_other == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
